// ==== Bender.yml ====
package:
  name: direction_binner

sources:
  # packages first, the binner table uses the cordic angle type
  - source/cordic_pkg.sv
  - source/binner_pkg.sv
  - source/sample_fifo.sv
  - source/cordic_vector.sv
  - source/direction_accumulator.sv
  - source/direction_binner_top.sv

  - target: test
    files:
      - verif/tb_clock.sv
      - verif/direction_binner_tb.sv

// ==== source/binner_pkg.sv ====
package binner_pkg;

    // pi/8 wide sectors around the full circle
    localparam int NUM_BINS = 16;

    typedef logic [$clog2(NUM_BINS)-1:0] bin_t;

    // upper half-plane edges in the cordic angle format
    // lower half uses the negated values
    localparam cordic_pkg::angle_t SECTOR_BOUNDS [NUM_BINS/2 + 1] = '{
        16'h0000,  // 0
        16'h0c91,  // pi/8
        16'h1922,
        16'h25b3,
        16'h3244,  // pi/2
        16'h3ed5,
        16'h4b66,
        16'h57f7,
        16'h6488   // pi
    };

endpackage

// ==== source/cordic_pkg.sv ====
package cordic_pkg;

    // signed 3.13 fixed point, range just under +-4 rad
    localparam int ANGLE_W = 16;

    typedef logic signed [ANGLE_W-1:0] angle_t;

    localparam angle_t ANGLE_PI = 16'h6488;

    // micro-rotation stages
    localparam int ITERATIONS = 14;

    // atan(2^-i) scaled by 2^13
    localparam angle_t ATAN_TABLE [ITERATIONS] = '{
        16'h1922,  // 45 deg
        16'h0ed6,
        16'h07d7,
        16'h03fb,
        16'h01ff,
        16'h0100,
        16'h0080,
        16'h0040,
        16'h0020,
        16'h0010,
        16'h0008,
        16'h0004,
        16'h0002,
        16'h0001   // last useful step at this precision
    };

endpackage

// ==== source/cordic_vector.sv ====
`timescale 1ns/100ps

module cordic_vector #(
    parameter int COORD_WIDTH  = 16,
    parameter int WEIGHT_WIDTH = 16
) (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic                           advance,
    input  logic                           in_valid,
    input  logic signed [COORD_WIDTH-1:0]  in_x,
    input  logic signed [COORD_WIDTH-1:0]  in_y,
    input  logic        [WEIGHT_WIDTH-1:0] in_weight,
    output logic                           out_valid,
    output cordic_pkg::angle_t             out_angle,
    output logic        [WEIGHT_WIDTH-1:0] out_weight
);

    localparam int ITER = cordic_pkg::ITERATIONS;
    localparam int XW   = COORD_WIDTH + 2;  // room for the ~1.65 gain and the negation

    // index 0 is the half-plane fold, index i+1 the result of micro-rotation i
    logic signed [XW-1:0]  x_q [ITER];
    logic signed [XW-1:0]  y_q [ITER];
    cordic_pkg::angle_t    z_q [ITER+1];
    logic                  v_q [ITER+1];
    logic [WEIGHT_WIDTH-1:0] w_q [ITER+1];
    logic                  out_valid_q;

    logic signed [XW-1:0] x_ext;
    logic signed [XW-1:0] y_ext;
    logic signed [XW-1:0] pre_x;
    logic signed [XW-1:0] pre_y;
    cordic_pkg::angle_t   pre_z;

    assign x_ext = in_x;  // sign extension
    assign y_ext = in_y;

    // fold the left half-plane by a half turn
    always_comb begin
        if (x_ext < 0) begin
            pre_x = -x_ext;
            pre_y = -y_ext;
            pre_z = (y_ext >= 0) ? cordic_pkg::ANGLE_PI : -cordic_pkg::ANGLE_PI;
        end else begin
            pre_x = x_ext;
            pre_y = y_ext;
            pre_z = '0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i <= ITER; i++) begin
                v_q[i] <= 1'b0;
            end
            out_valid_q <= 1'b0;
        end else if (advance) begin
            v_q[0] <= in_valid;
            for (int i = 0; i < ITER; i++) begin
                v_q[i+1] <= v_q[i];
            end
            out_valid_q <= v_q[ITER];
        end
    end

    always_ff @(posedge clk_in) begin
        if (advance) begin
            x_q[0] <= pre_x;
            y_q[0] <= pre_y;
            z_q[0] <= pre_z;
            w_q[0] <= in_weight;
        end
    end

    for (genvar i = 0; i < ITER; i++) begin : g_stage
        logic below;  // vector under the x-axis, rotate counter-clockwise

        assign below = y_q[i][XW-1];

        always_ff @(posedge clk_in) begin
            if (advance) begin
                z_q[i+1] <= below ? z_q[i] - cordic_pkg::ATAN_TABLE[i]
                                  : z_q[i] + cordic_pkg::ATAN_TABLE[i];
                w_q[i+1] <= w_q[i];
            end
        end

        // last stage only needs the angle
        if (i < ITER - 1) begin : g_xy
            always_ff @(posedge clk_in) begin
                if (advance) begin
                    x_q[i+1] <= below ? x_q[i] - (y_q[i] >>> i) : x_q[i] + (y_q[i] >>> i);
                    y_q[i+1] <= below ? y_q[i] + (x_q[i] >>> i) : y_q[i] - (x_q[i] >>> i);
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (advance) begin
            out_angle  <= z_q[ITER];
            out_weight <= w_q[ITER];
        end
    end

    // a held result is handed over only once the pipeline moves again
    assign out_valid = out_valid_q & advance;

endmodule

// ==== source/direction_accumulator.sv ====
`timescale 1ns/100ps

module direction_accumulator #(
    parameter int WEIGHT_WIDTH = 16,
    parameter int QUANTITY     = 199,
    parameter int OUT_CREDITS  = 2
) (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic                         angle_valid,
    input  cordic_pkg::angle_t           angle,
    input  logic [WEIGHT_WIDTH-1:0]      weight,
    input  logic                         result_credit,
    output logic                         advance,
    output logic                         result_valid,
    output binner_pkg::bin_t             result_bin,
    output logic [WEIGHT_WIDTH + $clog2(QUANTITY)-1:0] result_sum
);

    localparam int SUM_WIDTH = WEIGHT_WIDTH + $clog2(QUANTITY);
    localparam int CNT_W     = $clog2(QUANTITY + 1);
    localparam int CREDIT_W  = $clog2(OUT_CREDITS + 1);
    localparam int HALF      = binner_pkg::NUM_BINS / 2;

    logic [SUM_WIDTH-1:0] sums [binner_pkg::NUM_BINS];
    logic [CNT_W-1:0]     sample_cnt;
    logic [CREDIT_W-1:0]  credit_cnt;
    logic                 frame_full;
    logic                 send;
    binner_pkg::bin_t     sector;
    binner_pkg::bin_t     best_bin;
    logic [SUM_WIDTH-1:0] best_sum;

    // sector decode, +pi and anything outside the table land in bin 8
    always_comb begin
        sector = binner_pkg::bin_t'(HALF);
        for (int k = 0; k < HALF; k++) begin
            if (angle >= binner_pkg::SECTOR_BOUNDS[k] &&
                angle <  binner_pkg::SECTOR_BOUNDS[k+1]) begin
                sector = binner_pkg::bin_t'(k);
            end
            if (angle >= -binner_pkg::SECTOR_BOUNDS[HALF-k] &&
                angle <  -binner_pkg::SECTOR_BOUNDS[HALF-1-k]) begin
                sector = binner_pkg::bin_t'(HALF + k);
            end
        end
    end

    // peak search, strict compare keeps the lowest index on ties
    always_comb begin
        best_bin = '0;
        best_sum = sums[0];
        for (int i = 1; i < binner_pkg::NUM_BINS; i++) begin
            if (sums[i] > best_sum) begin
                best_bin = binner_pkg::bin_t'(i);
                best_sum = sums[i];
            end
        end
    end

    assign frame_full   = (sample_cnt == CNT_W'(QUANTITY));
    assign send         = frame_full & (credit_cnt != '0);
    assign advance      = ~frame_full | send;  // stall only while the result waits
    assign result_valid = send;
    assign result_bin   = best_bin;
    assign result_sum   = best_sum;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < binner_pkg::NUM_BINS; i++) begin
                sums[i] <= '0;
            end
            sample_cnt <= '0;
        end else if (send) begin
            // new frame starts, a sample arriving now is its first
            for (int i = 0; i < binner_pkg::NUM_BINS; i++) begin
                sums[i] <= (angle_valid && sector == binner_pkg::bin_t'(i)) ?
                           SUM_WIDTH'(weight) : '0;
            end
            sample_cnt <= angle_valid ? CNT_W'(1) : '0;
        end else if (angle_valid) begin
            sums[sector] <= sums[sector] + SUM_WIDTH'(weight);
            sample_cnt   <= sample_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            credit_cnt <= CREDIT_W'(OUT_CREDITS);
        end else begin
            case ({result_credit, send})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;  // none, or one in and one out
            endcase
        end
    end

    // sink only hands back credits that results have used up
    a_credit_bound: assert property (@(posedge clk_in) disable iff (rst_in)
        result_credit && !send |-> credit_cnt < CREDIT_W'(OUT_CREDITS))
        else $error("direction_accumulator: result credit returned beyond the granted count");

    // the cordic must hold its output while the frame result is pending
    a_no_sample_in_stall: assert property (@(posedge clk_in) disable iff (rst_in)
        angle_valid |-> advance)
        else $error("direction_accumulator: sample arrived during stall");

endmodule

// ==== source/direction_binner_top.sv ====
`timescale 1ns/100ps

module direction_binner_top #(
    parameter int COORD_WIDTH  = 16,
    parameter int WEIGHT_WIDTH = 16,
    parameter int QUANTITY     = 199,
    parameter int FIFO_DEPTH   = 4,
    parameter int OUT_CREDITS  = 2
) (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic                           sample_valid,
    input  logic signed [COORD_WIDTH-1:0]  sample_x,
    input  logic signed [COORD_WIDTH-1:0]  sample_y,
    input  logic        [WEIGHT_WIDTH-1:0] sample_weight,
    input  logic                           result_credit,
    output logic                           sample_credit,
    output logic                           result_valid,
    output binner_pkg::bin_t               result_bin,
    output logic [WEIGHT_WIDTH + $clog2(QUANTITY)-1:0] result_sum
);

    localparam int SUM_WIDTH = WEIGHT_WIDTH + $clog2(QUANTITY);

    logic                           advance;
    logic                           pop_valid;
    logic signed [COORD_WIDTH-1:0]  pop_x;
    logic signed [COORD_WIDTH-1:0]  pop_y;
    logic        [WEIGHT_WIDTH-1:0] pop_weight;
    logic                           angle_valid;
    cordic_pkg::angle_t             angle;
    logic        [WEIGHT_WIDTH-1:0] weight;
    logic        [SUM_WIDTH-1:0]    peak_sum;

    sample_fifo #(
        .COORD_WIDTH  (COORD_WIDTH),
        .WEIGHT_WIDTH (WEIGHT_WIDTH),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) u_fifo (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .push        (sample_valid),
        .push_x      (sample_x),
        .push_y      (sample_y),
        .push_weight (sample_weight),
        .advance     (advance),
        .pop_valid   (pop_valid),
        .pop_x       (pop_x),
        .pop_y       (pop_y),
        .pop_weight  (pop_weight),
        .credit      (sample_credit)
    );

    cordic_vector #(
        .COORD_WIDTH  (COORD_WIDTH),
        .WEIGHT_WIDTH (WEIGHT_WIDTH)
    ) u_cordic (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .advance    (advance),
        .in_valid   (pop_valid),
        .in_x       (pop_x),
        .in_y       (pop_y),
        .in_weight  (pop_weight),
        .out_valid  (angle_valid),
        .out_angle  (angle),
        .out_weight (weight)
    );

    direction_accumulator #(
        .WEIGHT_WIDTH (WEIGHT_WIDTH),
        .QUANTITY     (QUANTITY),
        .OUT_CREDITS  (OUT_CREDITS)
    ) u_accum (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .angle_valid   (angle_valid),
        .angle         (angle),
        .weight        (weight),
        .result_credit (result_credit),
        .advance       (advance),
        .result_valid  (result_valid),
        .result_bin    (result_bin),
        .result_sum    (peak_sum)
    );

    assign result_sum = peak_sum;

endmodule

// ==== source/sample_fifo.sv ====
`timescale 1ns/100ps

module sample_fifo #(
    parameter int COORD_WIDTH  = 16,
    parameter int WEIGHT_WIDTH = 16,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic                           push,
    input  logic signed [COORD_WIDTH-1:0]  push_x,
    input  logic signed [COORD_WIDTH-1:0]  push_y,
    input  logic        [WEIGHT_WIDTH-1:0] push_weight,
    input  logic                           advance,
    output logic                           pop_valid,
    output logic signed [COORD_WIDTH-1:0]  pop_x,
    output logic signed [COORD_WIDTH-1:0]  pop_y,
    output logic        [WEIGHT_WIDTH-1:0] pop_weight,
    output logic                           credit
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic signed [COORD_WIDTH-1:0]  x_mem [FIFO_DEPTH];
    logic signed [COORD_WIDTH-1:0]  y_mem [FIFO_DEPTH];
    logic        [WEIGHT_WIDTH-1:0] w_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full      = (fill == CNT_W'(FIFO_DEPTH));
    assign pop_valid = (fill != '0);  // registered fill, so no same-cycle bypass
    assign do_pop    = pop_valid & advance;
    assign do_push   = push & ~full;
    assign credit    = do_pop;        // one credit back per entry taken

    assign pop_x      = x_mem[rd_ptr];
    assign pop_y      = y_mem[rd_ptr];
    assign pop_weight = w_mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            x_mem[wr_ptr] <= push_x;
            y_mem[wr_ptr] <= push_y;
            w_mem[wr_ptr] <= push_weight;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill <= fill + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // upstream may only send while it holds a credit
    a_no_overflow: assert property (@(posedge clk_in) disable iff (rst_in) push |-> !full)
        else $error("sample_fifo: push into full buffer, upstream exceeded its credits");

endmodule

// ==== tb.f ====
source/cordic_pkg.sv
source/binner_pkg.sv
source/sample_fifo.sv
source/cordic_vector.sv
source/direction_accumulator.sv
source/direction_binner_top.sv
verif/tb_clock.sv
verif/direction_binner_tb.sv

// ==== verif/direction_binner_tb.sv ====
`timescale 1ns/100ps

module direction_binner_tb;

    localparam int  COORD_WIDTH  = 16;
    localparam int  WEIGHT_WIDTH = 16;
    localparam int  QUANTITY     = 8;
    localparam int  FIFO_DEPTH   = 4;
    localparam int  OUT_CREDITS  = 2;
    localparam int  SUM_WIDTH    = WEIGHT_WIDTH + $clog2(QUANTITY);
    localparam int  NUM_TESTS    = 5;
    localparam int  MAX_FRAMES   = 16;  // longest test, one frame per sector
    localparam int  WATCHDOG_CYCLES =
        NUM_TESTS * MAX_FRAMES * (QUANTITY + cordic_pkg::ITERATIONS + 10) + 200;
    localparam real PI           = 3.14159265358979;
    localparam real RADIUS       = 20000.0;

    logic                           clk_in;
    logic                           rst_in;
    logic                           sample_valid;
    logic signed [COORD_WIDTH-1:0]  sample_x;
    logic signed [COORD_WIDTH-1:0]  sample_y;
    logic        [WEIGHT_WIDTH-1:0] sample_weight;
    logic                           result_credit;
    logic                           sample_credit;
    logic                           result_valid;
    binner_pkg::bin_t               result_bin;
    logic        [SUM_WIDTH-1:0]    result_sum;

    logic [31:0] lcg_state;
    int          up_credits;     // upstream credits held by the driver
    int          sent_count;
    int          credit_pulses;
    int          result_count;
    int          owed_credits;   // result credits the sink still has to return
    logic        hold_credits;
    int          value_errors;
    int          protocol_errors;

    binner_pkg::bin_t        exp_bins [$];
    logic [SUM_WIDTH-1:0]    exp_sums [$];
    int                      frame_bin [QUANTITY];
    logic [WEIGHT_WIDTH-1:0] frame_w [QUANTITY];

    tb_clock #(.PERIOD(4.0), .RESET_CYCLES(5)) u_clock (.clk_in(clk_in), .rst_in(rst_in));

    direction_binner_top #(
        .COORD_WIDTH  (COORD_WIDTH),
        .WEIGHT_WIDTH (WEIGHT_WIDTH),
        .QUANTITY     (QUANTITY),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .OUT_CREDITS  (OUT_CREDITS)
    ) DUT (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .sample_valid  (sample_valid),
        .sample_x      (sample_x),
        .sample_y      (sample_y),
        .sample_weight (sample_weight),
        .result_credit (result_credit),
        .sample_credit (sample_credit),
        .result_valid  (result_valid),
        .result_bin    (result_bin),
        .result_sum    (result_sum)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_bin(input string name, input binner_pkg::bin_t got,
                             input binner_pkg::bin_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got);
            value_errors++;
        end
    endtask

    task automatic check_sum(input string name, input logic [SUM_WIDTH-1:0] got,
                             input logic [SUM_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got);
            value_errors++;
        end
    endtask

    // sector centre k*pi/8 + pi/16, same direction for the negative half
    task automatic send_sample(input int bin, input logic [WEIGHT_WIDTH-1:0] w);
        real a;
        a = bin * PI / 8.0 + PI / 16.0;
        while (up_credits == 0) @(negedge clk_in);
        sample_valid  = 1'b1;
        sample_x      = COORD_WIDTH'($rtoi(RADIUS * $cos(a)));
        sample_y      = COORD_WIDTH'($rtoi(RADIUS * $sin(a)));
        sample_weight = w;
        up_credits--;
        sent_count++;
        @(negedge clk_in);
        sample_valid = 1'b0;
    endtask

    // reference model, then the samples themselves
    task automatic send_frame();
        logic [SUM_WIDTH-1:0] sums [binner_pkg::NUM_BINS];
        logic [SUM_WIDTH-1:0] peak;
        int                   first;
        foreach (sums[b]) sums[b] = '0;
        for (int i = 0; i < QUANTITY; i++) begin
            sums[frame_bin[i]] += SUM_WIDTH'(frame_w[i]);
        end
        peak = '0;
        foreach (sums[b]) if (sums[b] > peak) peak = sums[b];
        first = binner_pkg::NUM_BINS - 1;
        for (int b = binner_pkg::NUM_BINS - 1; b >= 0; b--) begin
            if (sums[b] == peak) first = b;  // lowest index wins a tie
        end
        exp_bins.push_back(binner_pkg::bin_t'(first));
        exp_sums.push_back(peak);
        for (int i = 0; i < QUANTITY; i++) send_sample(frame_bin[i], frame_w[i]);
    endtask

    task automatic random_frame();
        for (int i = 0; i < QUANTITY; i++) begin
            frame_bin[i] = int'(next_rand() >> 28);
            frame_w[i]   = WEIGHT_WIDTH'(next_rand() >> 16);
        end
        send_frame();
    endtask

    task automatic wait_results();
        while (exp_bins.size() != 0 || owed_credits != 0) @(negedge clk_in);
        repeat (2) @(negedge clk_in);
    endtask

    task automatic idle_after_reset();
        repeat (10) begin
            check_flag("result_valid", result_valid, 1'b0);
            check_flag("sample_credit", sample_credit, 1'b0);
            @(negedge clk_in);
        end
    endtask

    task automatic single_sector_frames();
        for (int b = 0; b < binner_pkg::NUM_BINS; b++) begin
            for (int i = 0; i < QUANTITY; i++) begin
                frame_bin[i] = b;
                frame_w[i]   = WEIGHT_WIDTH'(next_rand() >> 16);
            end
            send_frame();
        end
        wait_results();
    endtask

    task automatic mixed_and_tied_frames();
        logic [WEIGHT_WIDTH-1:0] w;
        random_frame();
        w = WEIGHT_WIDTH'(next_rand() >> 16);
        for (int i = 0; i < QUANTITY; i++) begin
            frame_bin[i] = (i % 2) ? 13 : 6;  // equal peaks in 6 and 13
            frame_w[i]   = w;
        end
        send_frame();
        wait_results();
    endtask

    task automatic input_credit_flow();
        repeat (6) random_frame();
        wait_results();
        check_count("sample_credit pulses", credit_pulses, sent_count);
        check_count("upstream credits", up_credits, FIFO_DEPTH);
    endtask

    task automatic output_backpressure();
        int base;
        base = result_count;
        @(posedge clk_in);
        hold_credits = 1'b1;
        @(negedge clk_in);
        fork
            repeat (4) random_frame();
            begin
                while (result_count < base + OUT_CREDITS) @(negedge clk_in);
                repeat (60) @(negedge clk_in);
                check_count("results while stalled", result_count - base, OUT_CREDITS);
                @(posedge clk_in);
                hold_credits = 1'b0;
            end
        join
        wait_results();
    endtask

    // outputs are read at the rising edge, before the DUT updates
    always @(posedge clk_in) begin
        if (!rst_in) begin
            if (sample_credit) begin
                up_credits++;
                credit_pulses++;
                if (up_credits > FIFO_DEPTH) begin
                    $display("more upstream credits returned than samples sent");
                    protocol_errors++;
                end
            end
            if (result_valid) begin
                result_count++;
                owed_credits++;
                if (exp_bins.size() == 0) begin
                    $display("result arrived with no frame outstanding");
                    protocol_errors++;
                end else begin
                    check_bin("result_bin", result_bin, exp_bins.pop_front());
                    check_sum("result_sum", result_sum, exp_sums.pop_front());
                end
            end
        end
    end

    // sink hands back one result credit per result unless holding them
    always @(negedge clk_in) begin
        if (!hold_credits && owed_credits > 0) begin
            result_credit = 1'b1;
            owed_credits--;
        end else begin
            result_credit = 1'b0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("timeout after %0d cycles, results still missing", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        sample_valid    = 1'b0;
        sample_x        = '0;
        sample_y        = '0;
        sample_weight   = '0;
        result_credit   = 1'b0;
        lcg_state       = 32'h6ee6ee6e;
        up_credits      = FIFO_DEPTH;
        sent_count      = 0;
        credit_pulses   = 0;
        result_count    = 0;
        owed_credits    = 0;
        hold_credits    = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        @(negedge rst_in);
        @(negedge clk_in);
        idle_after_reset();
        single_sector_frames();
        mixed_and_tied_frames();
        input_credit_flow();
        output_backpressure();
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
    parameter real PERIOD       = 4.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk_in,
    output logic rst_in
);

    initial begin
        clk_in = 1'b0;
        forever #(PERIOD / 2.0) clk_in = ~clk_in;
    end

    initial begin
        rst_in = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_in <= 1'b0;  // released on an edge, like any other register
    end

endmodule
